// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - verilog/lsu_types_pkg.sv
      - verilog/mem_bus_pkg.sv
      - verilog/lsu_request_path.sv
      - verilog/lsu_load_align.sv
      - verilog/lsu_ctrl_fsm.sv
      - verilog/lsu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_lsu.sv

// File: all.f
+incdir+tests
verilog/lsu_types_pkg.sv
verilog/mem_bus_pkg.sv
verilog/lsu_request_path.sv
verilog/lsu_load_align.sv
verilog/lsu_ctrl_fsm.sv
verilog/lsu_top.sv
tests/tb_lsu.sv

// File: tests/lsu_ref.svh
/*
  reference model and compare tasks of the LSU testbench
  included inside tb_lsu and uses its counters n_checks and n_mismatch
  lanes are byte positions inside a 32-bit little-endian word
*/
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

////////////////////////////////////////////////////////////////////////////
// reference functions

// bytes touched by one access
function automatic int unsigned access_size(input lsu_types_pkg::data_type_e dt);
  case (dt)
    lsu_types_pkg::WORD: return 4;
    lsu_types_pkg::HALF: return 2;
    default:             return 1; // 2'b10 and 2'b11
  endcase
endfunction

// true when the access runs past lane 3
function automatic logic crosses_word(input lsu_types_pkg::data_type_e dt,
                                      input logic [1:0] ofs);
  return (32'(ofs) + access_size(dt)) > 4;
endfunction

// lanes covered by the access where the second part sees positions 4..7
function automatic logic [mem_bus_pkg::BE_W-1:0] ref_be(input lsu_types_pkg::data_type_e dt,
                                                        input logic [1:0] ofs,
                                                        input logic second);
  logic [mem_bus_pkg::BE_W-1:0] be;
  int unsigned pos;
  int unsigned first;
  int i;
  first = 32'(ofs);
  for (i = 0; i < mem_bus_pkg::BE_W; i++)
  begin
    pos   = second ? i + 4 : i;
    be[i] = (pos >= first) && (pos < first + access_size(dt));
  end
  return be;
endfunction

// register byte i lands on lane (i + ofs - reg_ofs) mod 4
function automatic logic [mem_bus_pkg::DATA_W-1:0] ref_wdata(input logic [31:0] wdata,
                                                             input logic [1:0] ofs,
                                                             input logic [1:0] reg_ofs);
  logic [31:0] res;
  logic [1:0]  lane;
  int i;
  for (i = 0; i < 4; i++)
  begin
    lane = i[1:0] + ofs - reg_ofs;
    res[8*lane +: 8] = wdata[8*i +: 8];
  end
  return res;
endfunction

// bytes from ofs upward across lo and hi and filled to 32 bits
function automatic logic [31:0] ref_load(input logic [31:0] lo, input logic [31:0] hi,
                                         input logic [1:0] ofs,
                                         input lsu_types_pkg::data_type_e dt,
                                         input lsu_types_pkg::sign_ext_e se);
  logic [63:0] dw;
  logic [31:0] res;
  logic        fill;
  int unsigned n;
  int b;
  dw  = {hi, lo} >> (8 * ofs);
  res = dw[31:0];
  n   = 8 * access_size(dt);
  case (se)
    lsu_types_pkg::ZERO_EXT: fill = 1'b0;
    lsu_types_pkg::ONE_EXT:  fill = 1'b1;
    default:                 fill = res[n-1]; // sign bit for SIGN_EXT and 2'b11
  endcase
  for (b = n; b < 32; b++)
    res[b] = fill;
  return res;
endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks

task automatic check_word(input string name, input logic [mem_bus_pkg::DATA_W-1:0] exp,
                          input logic [mem_bus_pkg::DATA_W-1:0] act);
  n_checks++;
  if (act !== exp)
  begin
    n_mismatch++;
    $display("MISMATCH %s: expected %h actual %h", name, exp, act);
  end
endtask

task automatic check_be(input string name, input logic [mem_bus_pkg::BE_W-1:0] exp,
                        input logic [mem_bus_pkg::BE_W-1:0] act);
  n_checks++;
  if (act !== exp)
  begin
    n_mismatch++;
    $display("MISMATCH %s: expected %b actual %b", name, exp, act);
  end
endtask

task automatic check_req(input string name, input mem_bus_pkg::mem_req_t exp,
                         input mem_bus_pkg::mem_req_t act);
  n_checks++;
  if (act !== exp)
  begin
    n_mismatch++;
    $display("MISMATCH %s: expected %h actual %h", name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  n_checks++;
  if (act !== exp)
  begin
    n_mismatch++;
    $display("MISMATCH %s: expected %b actual %b", name, exp, act);
  end
endtask

`endif

// File: tests/tb_lsu.sv
/*
  testbench of the load/store unit
  memory model of 16 words with grant after 0 to 2 cycles and rvalid one cycle after grant
  split accesses are reissued at address + 4 with misaligned set
  data_err_i is never raised
*/
`default_nettype none

module tb_lsu;
  timeunit 1ns;
  timeprecision 100ps;

  // 20 store and 43 load requests counting split parts, plus 3 handshake requests
  localparam int unsigned N_OPS          = 66;
  localparam int unsigned TIMEOUT_CYCLES = 40 * N_OPS;

  logic                    clk = 1'b0;
  logic                    rst_n;
  lsu_types_pkg::lsu_req_t ex_req;
  logic                    data_req_ex, ex_valid, data_err;
  logic                    data_req, data_gnt, data_rvalid;
  logic                    data_misaligned, lsu_ready_ex, lsu_ready_wb, busy;
  mem_bus_pkg::mem_req_t   mem_req;
  logic [31:0]             data_rdata, data_rdata_ex;

  logic [31:0] mem [16];       // word index is addr[5:2]
  logic [31:0] rng_state;
  logic        gnt_ready;      // responder side of the grant
  logic        gnt_hold;       // stimulus can withhold every grant
  logic [1:0]  gnt_wait;       // cycles still to wait before granting
  logic [32:0] exp_q [$];      // one {check load, expected data} entry per grant
  string       test_name;
  int unsigned n_checks, n_mismatch, n_other, cycle_cnt;

  `include "lsu_ref.svh"

  // xorshift32 whose state advances on every call
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  always #5 clk = ~clk;

  lsu_top #(
    .ADDR_W (32)
  ) u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_req_i          (ex_req),
    .data_req_ex_i     (data_req_ex),
    .ex_valid_i        (ex_valid),
    .data_rdata_ex_o   (data_rdata_ex),
    .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o    (lsu_ready_ex),
    .lsu_ready_wb_o    (lsu_ready_wb),
    .busy_o            (busy),
    .data_req_o        (data_req),
    .mem_req_o         (mem_req),
    .data_gnt_i        (data_gnt),
    .data_rvalid_i     (data_rvalid),
    .data_err_i        (data_err),
    .data_rdata_i      (data_rdata)
  );

  assign data_gnt = data_req && gnt_ready && !gnt_hold; // grant only a live request

  ////////////////////////////////////////////////////////////////////////////
  // memory responder that samples on the edge and drives 1 ns later

  always @(posedge clk)
  begin
    logic        accepted;
    logic [3:0]  idx;
    logic [31:0] rd_word;
    logic [31:0] idle_data;
    int i;
    accepted  = data_req && data_gnt;
    idx       = mem_req.addr[5:2];
    rd_word   = mem[idx];           // read before a store writes
    idle_data = next_rand();        // bus noise while rvalid is low
    if (accepted && mem_req.we)
      for (i = 0; i < 4; i++)
        if (mem_req.be[i])
          mem[idx][8*i +: 8] = mem_req.wdata[8*i +: 8];
    if (accepted)
      gnt_wait = 2'(next_rand() % 3);
    else if (data_req && gnt_wait != 0)
      gnt_wait = gnt_wait - 2'd1;
    #1;
    data_rvalid = accepted;
    data_rdata  = accepted ? rd_word : idle_data;
    gnt_ready   = (gnt_wait == 0);
  end

  ////////////////////////////////////////////////////////////////////////////
  // checker comparing DUT outputs with the reference on every edge

  always @(posedge clk)
  begin
    mem_bus_pkg::mem_req_t exp_req;
    logic [32:0] ent;
    logic [31:0] exp_load;
    logic [3:0]  idx;
    logic [1:0]  ofs;
    logic        first_part;
    if (rst_n)
    begin
      if (data_rvalid)              // pop before a grant of the same cycle pushes
      begin
        check_bit({test_name, " ready_wb at rvalid"}, 1'b1, lsu_ready_wb);
        if (exp_q.size() == 0)
        begin
          n_other++;
          $display("ERROR %s: rvalid arrived with no request outstanding", test_name);
        end
        else
        begin
          ent = exp_q.pop_front();
          if (ent[32])
            check_word({test_name, " load data"}, ent[31:0], data_rdata_ex);
        end
      end
      if (data_req && !data_gnt)    // waiting for grant
      begin
        check_bit({test_name, " ready_ex while waiting"}, 1'b0, lsu_ready_ex);
        check_bit({test_name, " busy while waiting"}, 1'b1, busy);
      end
      if (data_req && data_gnt)
      begin
        exp_req.addr  = ex_req.addr_useincr ? ex_req.operand_a + ex_req.operand_b
                                            : ex_req.operand_a;
        ofs           = exp_req.addr[1:0];
        idx           = exp_req.addr[5:2];
        exp_req.we    = ex_req.we;
        exp_req.be    = ref_be(ex_req.dtype, ofs, ex_req.misaligned);
        exp_req.wdata = ref_wdata(ex_req.wdata, ofs, ex_req.reg_offset);
        check_be({test_name, " be"}, exp_req.be, mem_req.be);
        check_word({test_name, " wdata"}, exp_req.wdata, mem_req.wdata);
        check_req({test_name, " request"}, exp_req, mem_req);
        check_bit({test_name, " ready_ex at grant"}, 1'b1, lsu_ready_ex);
        first_part = crosses_word(ex_req.dtype, ofs) && !ex_req.misaligned;
        check_bit({test_name, " misaligned"}, first_part, data_misaligned);
        if (ex_req.misaligned)      // second part whose data starts in the word below
          exp_load = ref_load(mem[idx - 4'd1], mem[idx], ofs, ex_req.dtype, ex_req.sign_ext);
        else
          exp_load = ref_load(mem[idx], mem[idx + 4'd1], ofs, ex_req.dtype, ex_req.sign_ext);
        exp_q.push_back({!ex_req.we && !first_part, exp_load});
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers start and end 1 ns after an edge

  task automatic wait_grant();
    do
      @(posedge clk);
    while (!(data_req && data_gnt));
  endtask

  task automatic wait_rvalid();
    do
      @(posedge clk);
    while (!data_rvalid);
  endtask

  // aligned word load at addr without increment
  task automatic set_word_load(input logic [31:0] addr);
    ex_req.we           = 1'b0;
    ex_req.dtype        = lsu_types_pkg::WORD;
    ex_req.sign_ext     = lsu_types_pkg::SIGN_EXT;
    ex_req.addr_useincr = 1'b0;
    ex_req.misaligned   = 1'b0;
    ex_req.operand_a    = addr;
  endtask

  // one access at a random word with a second part when it crosses a word
  task automatic run_access(input logic we, input lsu_types_pkg::data_type_e dt,
                            input lsu_types_pkg::sign_ext_e se, input logic [1:0] ofs);
    logic [31:0] addr;
    logic [31:0] r;
    addr = (next_rand() & 32'hffff_fffc) | 32'(ofs);
    r    = next_rand();
    ex_req.we           = we;
    ex_req.dtype        = dt;
    ex_req.sign_ext     = se;
    ex_req.wdata        = next_rand();
    ex_req.reg_offset   = r[1:0];
    ex_req.addr_useincr = r[2];
    ex_req.operand_b    = {24'h0, r[15:8]};
    ex_req.operand_a    = r[2] ? addr - ex_req.operand_b : addr;
    ex_req.misaligned   = 1'b0;
    data_req_ex = 1'b1;
    wait_grant();
    if (crosses_word(dt, ofs))
    begin
      #1;
      ex_req.misaligned = 1'b1;             // next word at the same lane offset
      ex_req.operand_a  = ex_req.operand_a + 32'd4;
      wait_grant();
    end
    #1;
    data_req_ex = 1'b0;
    wait_rvalid();
    #1;
  endtask

  task automatic print_summary();
    $display("summary: %0d checks, %0d mismatches, %0d other errors",
             n_checks, n_mismatch, n_other);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    int i, d, o, s;
    rst_n       = 1'b0;
    ex_req      = '0;
    data_req_ex = 1'b0;
    ex_valid    = 1'b1;
    data_err    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    gnt_ready   = 1'b1;
    gnt_hold    = 1'b0;
    gnt_wait    = '0;
    n_checks    = 0;
    n_mismatch  = 0;
    n_other     = 0;
    rng_state   = 32'd10339;
    test_name   = "reset";
    for (i = 0; i < 16; i++)
      mem[i] = next_rand();
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    check_bit("reset ready_ex", 1'b1, lsu_ready_ex);
    check_bit("reset ready_wb", 1'b1, lsu_ready_wb);
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset data_req", 1'b0, data_req);
    #1;

    // stores where dtype 3 is the second byte encoding
    for (d = 0; d < 4; d++)
      for (o = 0; o < 4; o++)
      begin
        test_name = $sformatf("store dt%0d ofs%0d", d, o);
        run_access(1'b1, lsu_types_pkg::data_type_e'(d[1:0]),
                   lsu_types_pkg::ZERO_EXT, o[1:0]);
      end

    // halfword and byte loads under all four extension codes
    for (d = 1; d < 3; d++)
      for (o = 0; o < 4; o++)
        for (s = 0; s < 4; s++)
        begin
          test_name = $sformatf("load dt%0d ofs%0d ext%0d", d, o, s);
          run_access(1'b0, lsu_types_pkg::data_type_e'(d[1:0]),
                     lsu_types_pkg::sign_ext_e'(s[1:0]), o[1:0]);
        end

    for (o = 0; o < 4; o++)
    begin
      test_name = $sformatf("word load ofs%0d", o);
      run_access(1'b0, lsu_types_pkg::WORD, lsu_types_pkg::SIGN_EXT, o[1:0]);
    end

    // request held without grant
    test_name = "gnt_hold";
    gnt_hold  = 1'b1;
    set_word_load(32'h0000_0010);
    data_req_ex = 1'b1;
    repeat (4)
    begin
      @(posedge clk);
      check_bit("gnt_hold ready_ex", 1'b0, lsu_ready_ex);
      check_bit("gnt_hold busy", 1'b1, busy);
    end
    #1 gnt_hold = 1'b0;
    wait_grant();
    #1 data_req_ex = 1'b0;
    wait_rvalid();
    #1;

    // execute stage stalled at grant so the next request must wait
    test_name = "ex_stall";
    ex_valid  = 1'b0;
    set_word_load(32'h0000_0020);
    data_req_ex = 1'b1;
    wait_grant();
    #1 set_word_load(32'h0000_0024);
    repeat (3)
    begin
      @(posedge clk);
      check_bit("ex_stall data_req", 1'b0, data_req);
      check_bit("ex_stall busy", 1'b1, busy);
    end
    #1 ex_valid = 1'b1;
    wait_grant();
    #1 data_req_ex = 1'b0;
    wait_rvalid();
    @(posedge clk);
    check_bit("ex_stall idle busy", 1'b0, busy);
    #1;

    print_summary();
    if (n_mismatch == 0 && n_other == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // run limit scaled with the number of requests
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    n_other++;
    $display("ERROR: timeout after %0d cycles, the LSU stopped answering", cycle_cnt);
    print_summary();
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lsu_ctrl_fsm.sv
/*
  request/response controller of the load/store unit
  one request outstanding at most, a new one may go out with the previous rvalid
  no new request is issued while the execute stage is stalled after a grant
*/
`default_nettype none

module lsu_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  input  logic ex_valid_i,
  output logic data_req_o,
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RVALID,          // request granted, response pending
    WAIT_RVALID_EX_STALL, // granted while ex was stalled
    IDLE_EX_STALL         // response back, ex still stalled
  } state_e;

  state_e state_q, state_d;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and strobes

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        data_req_o = data_req_ex_i;
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i || data_err_i; // held until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i; // wb stalls only on us
        if (data_rvalid_i)
        begin
          data_req_o = data_req_ex_i;   // back-to-back request
          if (data_req_ex_i)
          begin
            lsu_ready_ex_o = data_gnt_i || data_err_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
            else
              state_d = IDLE;           // retry the request from IDLE
          end
          else
          begin
            state_d = IDLE;
          end
        end
      end

      WAIT_RVALID_EX_STALL:
      begin
        // no new request here, data is caught by the load path anyway
        if (data_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = WAIT_RVALID;        // stall gone, wait normally
      end

      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  assign busy_o = (state_q != IDLE) || data_req_o;

endmodule

`default_nettype wire

// File: verilog/lsu_load_align.sv
/*
  load side of the load/store unit
  context is captured on every grant, data is aligned in the rvalid cycle
  a split load is assembled from the raw first response held in rdata_q
  data_rdata_ex_o is undefined until the first load has returned
*/
`default_nettype none

module lsu_load_align (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    data_gnt_i,
  input  logic                                    data_rvalid_i,
  input  lsu_types_pkg::lsu_req_t                 ex_req_i,
  input  logic [mem_bus_pkg::LANE_OFS_W-1:0]      lane_ofs_i,
  input  logic                                    first_split_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]          data_rdata_i,
  output logic [lsu_types_pkg::XLEN-1:0]          data_rdata_ex_o
);

  lsu_types_pkg::rsp_ctx_t            ctx_q;     // context of the outstanding access
  logic [mem_bus_pkg::DATA_W-1:0]     rdata_q;   // partial word or last result
  logic [lsu_types_pkg::XLEN-1:0]     word_asm;  // word, possibly joined across two words
  logic [15:0]                        half_raw;
  logic [7:0]                         byte_raw;
  logic [lsu_types_pkg::XLEN-1:0]     rdata_ext; // aligned and extended result

  // upper fill bit for the given extension mode
  function automatic logic fill_bit(input lsu_types_pkg::sign_ext_e mode, input logic msb);
    case (mode)
      lsu_types_pkg::ZERO_EXT: fill_bit = 1'b0;
      lsu_types_pkg::ONE_EXT:  fill_bit = 1'b1;
      default:                 fill_bit = msb; // SIGN_EXT and 2'b11
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // response context

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctx_q <= '0;
    end
    else if (data_gnt_i)
    begin
      ctx_q.dtype    <= ex_req_i.dtype;
      ctx_q.offset   <= lane_ofs_i;
      ctx_q.sign_ext <= ex_req_i.sign_ext;
      ctx_q.we       <= ex_req_i.we;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lane selection

  always_comb
  begin
    // words: the low lanes of this response go on top of the held upper lanes
    case (ctx_q.offset)
      2'b00: word_asm = data_rdata_i;
      2'b01: word_asm = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10: word_asm = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_asm = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase

    // halfwords, offset 3 only occurs as second part
    case (ctx_q.offset)
      2'b00: half_raw = data_rdata_i[15:0];
      2'b01: half_raw = data_rdata_i[23:8];
      2'b10: half_raw = data_rdata_i[31:16];
      default: half_raw = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase

    byte_raw = data_rdata_i[8*ctx_q.offset +: 8];
  end

  ////////////////////////////////////////////////////////////////////////////
  // extension

  always_comb
  begin
    case (ctx_q.dtype)
      lsu_types_pkg::WORD: rdata_ext = word_asm;
      lsu_types_pkg::HALF:
        rdata_ext = {{16{fill_bit(ctx_q.sign_ext, half_raw[15])}}, half_raw};
      default:
        rdata_ext = {{24{fill_bit(ctx_q.sign_ext, byte_raw[7])}}, byte_raw};
    endcase
  end

  // first part keeps the raw word for assembly, otherwise keep the result
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !ctx_q.we)
    begin
      if (first_split_i || ex_req_i.misaligned)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q; // hold after rvalid

endmodule

`default_nettype wire

// File: verilog/lsu_request_path.sv
/*
  request side of the load/store unit, fully combinational
  ADDR_W may range from 2 to 32, upper address bits are cut off by the adder
  a split access needs the execute stage to reissue the second part at the next
  word with ex_req_i.misaligned set
*/
`default_nettype none

module lsu_request_path #(
  parameter int unsigned ADDR_W = 32
) (
  input  lsu_types_pkg::lsu_req_t                 ex_req_i,
  input  logic                                    data_req_ex_i,
  output mem_bus_pkg::mem_req_t                   mem_req_o,
  output logic [mem_bus_pkg::LANE_OFS_W-1:0]      lane_ofs_o,
  output logic                                    data_misaligned_o
);

  logic [ADDR_W-1:0]                    addr;      // effective address
  logic [mem_bus_pkg::LANE_OFS_W-1:0]   wdata_ofs; // lane rotation for store data
  logic [mem_bus_pkg::BE_W-1:0]         be;
  logic [mem_bus_pkg::DATA_W-1:0]       wdata_rot;

  ////////////////////////////////////////////////////////////////////////////
  // address generation

  assign addr = ex_req_i.addr_useincr ?
                ex_req_i.operand_a[ADDR_W-1:0] + ex_req_i.operand_b[ADDR_W-1:0] :
                ex_req_i.operand_a[ADDR_W-1:0];

  assign lane_ofs_o = addr[mem_bus_pkg::LANE_OFS_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables

  always_comb
  begin
    case (ex_req_i.dtype)
      lsu_types_pkg::WORD:
      begin
        if (!ex_req_i.misaligned)
          be = 4'b1111 << lane_ofs_o;             // lanes from the offset upward
        else
          be = ~(4'b1111 << lane_ofs_o);          // the remaining low lanes, 0 never used
      end
      lsu_types_pkg::HALF:
      begin
        if (!ex_req_i.misaligned)
          be = (lane_ofs_o == 2'b11) ? 4'b1000 : (4'b0011 << lane_ofs_o);
        else
          be = 4'b0001;                            // upper byte of a split halfword
      end
      default: be = 4'b0001 << lane_ofs_o;        // byte, both encodings
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // store data rotation

  // address lane minus register lane, wraps modulo 4
  assign wdata_ofs = lane_ofs_o - ex_req_i.reg_offset;

  always_comb
  begin
    case (wdata_ofs)
      2'b00: wdata_rot = ex_req_i.wdata;
      2'b01: wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10: wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // split detection, only for the first part of an access

  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !ex_req_i.misaligned)
    begin
      case (ex_req_i.dtype)
        lsu_types_pkg::WORD: data_misaligned_o = (lane_ofs_o != 2'b00);
        lsu_types_pkg::HALF: data_misaligned_o = (lane_ofs_o == 2'b11);
        default:             data_misaligned_o = 1'b0; // a byte never crosses a word
      endcase
    end
  end

  // bus request, upper address bits zero
  always_comb
  begin
    mem_req_o              = '0;
    mem_req_o.addr[ADDR_W-1:0] = addr;
    mem_req_o.we           = ex_req_i.we;
    mem_req_o.be           = be;
    mem_req_o.wdata        = wdata_rot;
  end

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
/*
  load/store unit of a 32-bit RISC-V core
  ADDR_W sets the width of the address adder, 2 to 32
  the execute stage reissues the second part of a split access itself
*/
`default_nettype none

module lsu_top #(
  parameter int unsigned ADDR_W = 32
) (
  input  logic                                clk,
  input  logic                                rst_n,

  // execute stage
  input  lsu_types_pkg::lsu_req_t             ex_req_i,
  input  logic                                data_req_ex_i,
  input  logic                                ex_valid_i,
  output logic [lsu_types_pkg::XLEN-1:0]      data_rdata_ex_o,
  output logic                                data_misaligned_o, // to the controller of the core
  output logic                                lsu_ready_ex_o,
  output logic                                lsu_ready_wb_o,
  output logic                                busy_o,

  // data memory
  output logic                                data_req_o,
  output mem_bus_pkg::mem_req_t               mem_req_o,
  input  logic                                data_gnt_i,
  input  logic                                data_rvalid_i,
  input  logic                                data_err_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]      data_rdata_i
);

  logic [mem_bus_pkg::LANE_OFS_W-1:0] lane_ofs; // address offset, computed once

  ////////////////////////////////////////////////////////////////////////////
  // request side

  lsu_request_path #(
    .ADDR_W (ADDR_W)
  ) u_request_path (
    .ex_req_i          (ex_req_i),
    .data_req_ex_i     (data_req_ex_i),
    .mem_req_o         (mem_req_o),
    .lane_ofs_o        (lane_ofs),
    .data_misaligned_o (data_misaligned_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // response side

  lsu_load_align u_load_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .ex_req_i        (ex_req_i),
    .lane_ofs_i      (lane_ofs),
    .first_split_i   (data_misaligned_o), // first part of a split load
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

  // handshake and stalls
  lsu_ctrl_fsm u_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .ex_valid_i     (ex_valid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

`default_nettype wire

// File: verilog/lsu_types_pkg.sv
/*
  core-side types of the load/store unit
  data_type_e: encodings 10 and 11 both select a byte access
  sign_ext_e: encoding 11 behaves like SIGN_EXT
  lsu_req_t is driven by the execute stage and must be stable while a request waits
*/
`default_nettype none

package lsu_types_pkg;

  localparam int unsigned XLEN = 32; // register width of the core

  // access size, 2'b11 is an alias of BYTE and is caught by default branches
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } data_type_e;

  // fill mode for the upper bits of a load result
  typedef enum logic [1:0] {
    ZERO_EXT = 2'b00,
    SIGN_EXT = 2'b01, // 2'b11 falls back to sign extension
    ONE_EXT  = 2'b10
  } sign_ext_e;

  // request as it leaves the execute stage
  typedef struct packed {
    logic                we;           // store when set
    data_type_e          dtype;
    logic [XLEN-1:0]     wdata;        // store data, register aligned
    logic [1:0]          reg_offset;   // byte offset of the data inside the register
    sign_ext_e           sign_ext;
    logic [XLEN-1:0]     operand_a;    // base address
    logic [XLEN-1:0]     operand_b;    // address increment
    logic                addr_useincr; // a + b when set, a alone otherwise
    logic                misaligned;   // second part of a split access
  } lsu_req_t;

  // response context, captured when the memory grants
  typedef struct packed {
    data_type_e dtype;
    logic [1:0] offset;   // lane offset of the granted address
    sign_ext_e  sign_ext;
    logic       we;
  } rsp_ctx_t;

endpackage

`default_nettype wire

// File: verilog/mem_bus_pkg.sv
/*
  data bus of the load/store unit
  plain req/gnt/rvalid bus, one outstanding request, no response back-pressure
  the address field is always 32 bits, narrower LSU addresses are zero-extended
*/
`default_nettype none

package mem_bus_pkg;

  localparam int unsigned DATA_W      = 32;         // bus data width
  localparam int unsigned BE_W        = DATA_W / 8; // one enable per byte lane
  localparam int unsigned LANE_OFS_W  = 2;          // byte offset inside a bus word
  localparam int unsigned BUS_ADDR_W  = 32;         // address field of the request

  // request to memory, valid while data_req_o is high
  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    logic                  we;
    logic [BE_W-1:0]       be;    // byte lanes written on a store
    logic [DATA_W-1:0]     wdata; // already rotated to the addressed lanes
  } mem_req_t;

endpackage

`default_nettype wire
